// File: rtl/mem_sys_pkg.sv
/* Shared widths, types and structs for the three-source memory port.
   Line store holds 16 lines; address bits above the line index are ignored. */
package mem_sys_pkg;

    localparam int ADDR_WIDTH     = 32;
    localparam int LINE_WIDTH     = 512;
    localparam int NUM_LINES      = 16;
    localparam int LINE_IDX_WIDTH = 4;
    localparam int ACCESS_CYCLES  = 4;
    localparam int TIMER_WIDTH    = 3;

    typedef logic [ADDR_WIDTH-1:0]     addr_t;
    typedef logic [LINE_WIDTH-1:0]     line_t;
    typedef logic [LINE_IDX_WIDTH-1:0] line_idx_t;

    // Encoding 3 is reserved and behaves as idle
    typedef enum logic [1:0] {
        OP_IDLE  = 2'd0,
        OP_READ  = 2'd1,
        OP_WRITE = 2'd2
    } mem_op_e;

    typedef struct packed {
        mem_op_e op;
        addr_t   raw_address;
        addr_t   address_offset;
        line_t   wdata;
    } mem_req_t;

    typedef struct packed {
        line_t rdata;
        logic  tx_done;
        logic  rd_valid;
    } mem_rsp_t;

    typedef enum logic [1:0] {SRC1, SRC2, SRC3} src_sel_e;

    typedef enum logic [1:0] {CTRL_IDLE, CTRL_WAIT, CTRL_DONE} ctrl_state_e;

    // True only for the two real operations
    function automatic logic op_active(mem_op_e op);
        return (op == OP_READ) || (op == OP_WRITE);
    endfunction

endpackage

// File: rtl/mem_access_timer.sv
/* Loadable down-counter for the fixed access delay; holds at zero when idle.
   Expired is high for one cycle, ACCESS_CYCLES cycles after the load. */
`timescale 1ns/1ps

module mem_access_timer import mem_sys_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic timer_load,
    output logic timer_expired
);

    logic [TIMER_WIDTH-1:0] count_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (timer_load) begin
            count_q <= TIMER_WIDTH'(ACCESS_CYCLES);
        end else if (count_q != '0) begin
            count_q <= count_q - 1'b1;
        end
    end

    // Last wait cycle
    assign timer_expired = (count_q == TIMER_WIDTH'(1));

endmodule

// File: rtl/mem_line_store.sv
/* 16 x 512-bit line storage; contents come up undefined after reset.
   Read data is registered and holds until the next read. */
`timescale 1ns/1ps

module mem_line_store import mem_sys_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  line_idx_t line_idx,
    input  logic      wr_en,
    input  logic      rd_en,
    input  line_t     wdata,
    output line_t     rdata
);

    line_t lines_q [NUM_LINES];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            lines_q[line_idx] <= wdata;
        end
    end

    // Read port, cleared on reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (rd_en) begin
            rdata <= lines_q[line_idx];
        end
    end

endmodule

// File: rtl/mem_ctrl.sv
/* One transaction at a time; request is latched on acceptance so the arbiter may rotate.
   Accept cycle to tx_done cycle spans ACCESS_CYCLES + 2 cycles, both ends counted. */
`timescale 1ns/1ps

module mem_ctrl import mem_sys_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  mem_req_t  ctrl_req,
    output mem_rsp_t  ctrl_rsp,
    output logic      timer_load,
    input  logic      timer_expired,
    output line_idx_t line_idx,
    output logic      wr_en,
    output logic      rd_en,
    output line_t     wdata,
    input  line_t     rdata
);

    ctrl_state_e state_q;
    ctrl_state_e state_next;
    mem_op_e     op_q;
    line_idx_t   idx_q;
    line_t       wdata_q;
    addr_t       addr_sum;
    logic        accept;

    assign accept     = (state_q == CTRL_IDLE) && op_active(ctrl_req.op);
    assign timer_load = accept;

    // Upper bits of the sum fall outside the store
    assign addr_sum = ctrl_req.raw_address + ctrl_req.address_offset;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= CTRL_IDLE;
            op_q    <= OP_IDLE;
        end else begin
            state_q <= state_next;
            if (accept) begin
                op_q <= ctrl_req.op;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            idx_q   <= addr_sum[LINE_IDX_WIDTH-1:0];
            wdata_q <= ctrl_req.wdata;
        end
    end

    always_comb begin
        state_next = state_q;
        case (state_q)
            CTRL_IDLE: if (accept) state_next = CTRL_WAIT;
            CTRL_WAIT: if (timer_expired) state_next = CTRL_DONE;
            default:   state_next = CTRL_IDLE;
        endcase
    end

    // Store access fires in the last wait cycle
    assign wr_en    = (state_q == CTRL_WAIT) && timer_expired && (op_q == OP_WRITE);
    assign rd_en    = (state_q == CTRL_WAIT) && timer_expired && (op_q == OP_READ);
    assign line_idx = idx_q;
    assign wdata    = wdata_q;

    always_comb begin
        ctrl_rsp = '0;
        if (state_q == CTRL_DONE) begin
            ctrl_rsp.tx_done  = 1'b1;
            ctrl_rsp.rd_valid = (op_q == OP_READ);
            if (op_q == OP_READ) begin
                ctrl_rsp.rdata = rdata;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(wr_en && rd_en))
    else $error("write and read enables high together");

    assert property (@(posedge clk) disable iff (!rst_n) ctrl_rsp.tx_done |=> !ctrl_rsp.tx_done)
    else $error("tx_done held longer than one cycle");

endmodule

// File: rtl/mem_arbiter.sv
/* Round-robin routing of three requesters onto one controller, combinational both ways.
   A source keeps the grant while its op is active; unselected sources see zero. */
`timescale 1ns/1ps

module mem_arbiter import mem_sys_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  mem_req_t req_src1,
    input  mem_req_t req_src2,
    input  mem_req_t req_src3,
    output mem_rsp_t rsp_src1,
    output mem_rsp_t rsp_src2,
    output mem_rsp_t rsp_src3,
    output mem_req_t ctrl_req,
    input  mem_rsp_t ctrl_rsp
);

    src_sel_e sel_q;
    src_sel_e sel_next;
    logic     sel_busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel_q <= SRC1;
        end else begin
            sel_q <= sel_next;
        end
    end

    // Hold while the selected source has a transaction open
    assign sel_busy = op_active(ctrl_req.op) && !ctrl_rsp.tx_done;

    always_comb begin
        ctrl_req = '0;
        rsp_src1 = '0;
        rsp_src2 = '0;
        rsp_src3 = '0;
        sel_next = sel_q;
        case (sel_q)
            SRC1: begin
                ctrl_req = req_src1;
                rsp_src1 = ctrl_rsp;
            end
            SRC2: begin
                ctrl_req = req_src2;
                rsp_src2 = ctrl_rsp;
            end
            SRC3: begin
                ctrl_req = req_src3;
                rsp_src3 = ctrl_rsp;
            end
            default: begin
                ctrl_req = '0;
            end
        endcase

        if (!sel_busy) begin
            case (sel_q)
                SRC1:    sel_next = SRC2;
                SRC2:    sel_next = SRC3;
                default: sel_next = SRC1;
            endcase
        end
    end

    // Completion goes only to the granted source while it still holds its request
    assert property (@(posedge clk) disable iff (!rst_n)
        ctrl_rsp.tx_done |->
            op_active(ctrl_req.op) &&
            (rsp_src1.tx_done == (sel_q == SRC1)) &&
            (rsp_src2.tx_done == (sel_q == SRC2)) &&
            (rsp_src3.tx_done == (sel_q == SRC3)))
    else $error("tx_done missed the granted source or reached another one");

    // No rotation away from an open transaction
    assert property (@(posedge clk) disable iff (!rst_n)
        sel_busy |=> $stable(sel_q))
    else $error("arbiter left a source with an open transaction");

endmodule

// File: rtl/mem_subsystem_top.sv
/* Three requesters sharing one line store through a round-robin arbiter.
   Requests are held until tx_done; one transaction is in flight at a time. */
`timescale 1ns/1ps

module mem_subsystem_top import mem_sys_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  mem_req_t req_src1,
    input  mem_req_t req_src2,
    input  mem_req_t req_src3,
    output mem_rsp_t rsp_src1,
    output mem_rsp_t rsp_src2,
    output mem_rsp_t rsp_src3
);

    mem_req_t  ctrl_req;
    mem_rsp_t  ctrl_rsp;
    logic      timer_load;
    logic      timer_expired;
    line_idx_t line_idx;
    logic      wr_en;
    logic      rd_en;
    line_t     wdata;
    line_t     rdata;

    mem_arbiter u_arbiter (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_src1 (req_src1),
        .req_src2 (req_src2),
        .req_src3 (req_src3),
        .rsp_src1 (rsp_src1),
        .rsp_src2 (rsp_src2),
        .rsp_src3 (rsp_src3),
        .ctrl_req (ctrl_req),
        .ctrl_rsp (ctrl_rsp)
    );

    mem_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .ctrl_req      (ctrl_req),
        .ctrl_rsp      (ctrl_rsp),
        .timer_load    (timer_load),
        .timer_expired (timer_expired),
        .line_idx      (line_idx),
        .wr_en         (wr_en),
        .rd_en         (rd_en),
        .wdata         (wdata),
        .rdata         (rdata)
    );

    mem_access_timer u_timer (
        .clk           (clk),
        .rst_n         (rst_n),
        .timer_load    (timer_load),
        .timer_expired (timer_expired)
    );

    mem_line_store u_store (
        .clk      (clk),
        .rst_n    (rst_n),
        .line_idx (line_idx),
        .wr_en    (wr_en),
        .rd_en    (rd_en),
        .wdata    (wdata),
        .rdata    (rdata)
    );

endmodule

// File: tb/tb_mem_subsystem.sv
/* Table-driven testbench for the shared memory port; the first mismatch ends the run.
   A cycle model of arbiter rotation and controller latency predicts every strobe. */
`timescale 1ns/1ps

module tb_mem_subsystem import mem_sys_pkg::*; ();

    // Accept cycle to tx_done cycle, both ends counted
    localparam int DONE_LATENCY   = ACCESS_CYCLES + 2;
    localparam int TIMEOUT_CYCLES = 64;
    localparam int IDLE_CYCLES    = 5;
    localparam int RANDOM_OPS     = 40;

    typedef struct packed {
        src_sel_e src;
        mem_op_e  op;
        addr_t    raw;
        addr_t    offset;
        line_t    wdata;
        logic     joined;
    } entry_t;

    logic     clk;
    logic     rst_n;
    mem_req_t req_src1;
    mem_req_t req_src2;
    mem_req_t req_src3;
    mem_rsp_t rsp_src1;
    mem_rsp_t rsp_src2;
    mem_rsp_t rsp_src3;

    integer   seed;
    entry_t   tbl[$];
    mem_req_t drv_req [3];
    line_t    ref_lines [NUM_LINES];
    int       done_count [3];

    // Model of the current cycle
    src_sel_e  exp_sel;
    int        exp_cnt;
    src_sel_e  exp_src;
    mem_op_e   exp_op;
    line_idx_t exp_idx;
    line_t     exp_wdata;

    mem_subsystem_top UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_src1 (req_src1),
        .req_src2 (req_src2),
        .req_src3 (req_src3),
        .rsp_src1 (rsp_src1),
        .rsp_src2 (rsp_src2),
        .rsp_src3 (rsp_src3)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic compare_line(input string name, input line_t exp, input line_t act);
        if (act !== exp) begin
            report_failure($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("[ERROR] %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic compare_src(input string name, input src_sel_e exp, input src_sel_e act);
        if (act !== exp) begin
            report_failure($sformatf("[ERROR] %s expected %s actual %s",
                name, exp.name(), act.name()));
        end
    endtask

    function automatic src_sel_e next_src(input src_sel_e s);
        case (s)
            SRC1:    return SRC2;
            SRC2:    return SRC3;
            default: return SRC1;
        endcase
    endfunction

    function automatic mem_req_t req_of(input src_sel_e s);
        case (s)
            SRC1:    return req_src1;
            SRC2:    return req_src2;
            default: return req_src3;
        endcase
    endfunction

    function automatic mem_rsp_t rsp_of(input int s);
        case (s)
            0:       return rsp_src1;
            1:       return rsp_src2;
            default: return rsp_src3;
        endcase
    endfunction

    function automatic line_t random_line();
        line_t v;
        int    k;
        for (k = 0; k < LINE_WIDTH / 32; k++) begin
            v[k*32 +: 32] = $random(seed);
        end
        return v;
    endfunction

    function automatic src_sel_e random_src();
        int unsigned r;
        r = $random(seed);
        case (r % 3)
            0:       return SRC1;
            1:       return SRC2;
            default: return SRC3;
        endcase
    endfunction

    task automatic add_entry(input src_sel_e src, input mem_op_e op, input addr_t raw,
                             input addr_t offset, input line_t wdata, input logic joined);
        entry_t e;
        e.src    = src;
        e.op     = op;
        e.raw    = raw;
        e.offset = offset;
        e.wdata  = wdata;
        e.joined = joined;
        tbl.push_back(e);
    endtask

    // Random raw address with an offset whose sum lands on line idx
    task automatic add_random_access(input mem_op_e op, input int idx);
        addr_t raw;
        addr_t off;
        raw = $random(seed);
        off = addr_t'(idx) - raw + (addr_t'($random(seed)) << LINE_IDX_WIDTH);
        add_entry(random_src(), op, raw, off, (op == OP_WRITE) ? random_line() : '0, 1'b0);
    endtask

    task automatic build_table();
        int          k;
        int unsigned r;
        // Write then read back on one source
        add_entry(SRC1, OP_WRITE, 32'h0000_0005, 32'h0000_0000, random_line(), 1'b0);
        add_entry(SRC1, OP_READ,  32'h0000_0005, 32'h0000_0000, '0, 1'b0);
        add_entry(SRC3, OP_WRITE, 32'h0000_0008, 32'h0000_0001, random_line(), 1'b0);
        add_entry(SRC3, OP_READ,  32'h0000_0009, 32'h0000_0000, '0, 1'b0);
        // Same line 3 through different address pairs, upper bits ignored
        add_entry(SRC2, OP_WRITE, 32'h0000_0010, 32'h0000_0003, random_line(), 1'b0);
        add_entry(SRC1, OP_READ,  32'hffff_0001, 32'h0000_0002, '0, 1'b0);
        add_entry(SRC3, OP_READ,  32'hffff_ffff, 32'h0000_0004, '0, 1'b0);
        add_entry(SRC2, OP_READ,  32'h1234_5600, 32'h0000_0003, '0, 1'b0);
        // All three sources at once
        add_entry(SRC1, OP_WRITE, 32'h0000_0007, 32'h0000_0000, random_line(), 1'b1);
        add_entry(SRC2, OP_READ,  32'h0000_0005, 32'h0000_0000, '0, 1'b1);
        add_entry(SRC3, OP_READ,  32'h0000_0003, 32'h0000_0000, '0, 1'b0);
        add_entry(SRC1, OP_READ,  32'h0000_0007, 32'h0000_0000, '0, 1'b1);
        add_entry(SRC2, OP_WRITE, 32'h0000_0004, 32'h0000_0005, random_line(), 1'b1);
        add_entry(SRC3, OP_READ,  32'h0000_0009, 32'h0000_0000, '0, 1'b0);
        // Fill every line before random reads
        for (k = 0; k < NUM_LINES; k++) begin
            add_random_access(OP_WRITE, k);
        end
        for (k = 0; k < RANDOM_OPS; k++) begin
            r = $random(seed);
            add_random_access(r[0] ? OP_READ : OP_WRITE, int'(r[7:4]));
        end
    endtask

    // Checks the current cycle against the model, then steps the model
    task automatic check_cycle(input string name, input logic idle_check);
        mem_req_t sel_req;
        mem_rsp_t rsp;
        logic     exp_done;
        logic     strobe;
        logic     sel_active;
        src_sel_e seen;
        int       s;
        sel_req  = req_of(exp_sel);
        exp_done = (exp_cnt == 1);
        if (exp_done) begin
            if (!rsp_src1.tx_done && !rsp_src2.tx_done && !rsp_src3.tx_done) begin
                report_failure($sformatf("%s: no source saw tx_done when it was due", name));
            end else begin
                seen = rsp_src1.tx_done ? SRC1 : (rsp_src2.tx_done ? SRC2 : SRC3);
                compare_src({name, " tx_done order"}, exp_src, seen);
            end
        end
        for (s = 0; s < 3; s++) begin
            rsp    = rsp_of(s);
            strobe = exp_done && (int'(exp_src) == s);
            compare_bit($sformatf("%s src%0d tx_done", name, s + 1), strobe, rsp.tx_done);
            compare_bit($sformatf("%s src%0d rd_valid", name, s + 1),
                strobe && (exp_op == OP_READ), rsp.rd_valid);
            if (strobe && (exp_op == OP_READ)) begin
                compare_line($sformatf("%s src%0d rdata", name, s + 1),
                    ref_lines[exp_idx], rsp.rdata);
            end
            if (idle_check) begin
                compare_line($sformatf("%s src%0d rdata", name, s + 1), '0, rsp.rdata);
            end
        end
        // Completion in this cycle
        if (exp_done) begin
            if (exp_op == OP_WRITE) begin
                ref_lines[exp_idx] = exp_wdata;
            end
            drv_req[int'(exp_src)].op = OP_IDLE;
            done_count[int'(exp_src)]++;
        end
        sel_active = (sel_req.op == OP_READ) || (sel_req.op == OP_WRITE);
        if ((exp_cnt == 0) && sel_active) begin
            exp_cnt   = DONE_LATENCY - 1;
            exp_src   = exp_sel;
            exp_op    = sel_req.op;
            exp_idx   = line_idx_t'(sel_req.raw_address + sel_req.address_offset);
            exp_wdata = sel_req.wdata;
        end else if (exp_cnt != 0) begin
            exp_cnt--;
        end
        // Arbiter holds on an open transaction, otherwise rotates
        if (!(sel_active && !exp_done)) begin
            exp_sel = next_src(exp_sel);
        end
    endtask

    // Entered and left at a falling edge
    task automatic advance(input string name, input logic idle_check);
        check_cycle(name, idle_check);
        @(posedge clk);
        req_src1 <= drv_req[0];
        req_src2 <= drv_req[1];
        req_src3 <= drv_req[2];
        @(negedge clk);
    endtask

    task automatic run_batch(input string name, input logic [2:0] pending);
        int   cycles;
        int   s;
        logic all_done;
        for (s = 0; s < 3; s++) begin
            done_count[s] = 0;
        end
        cycles   = 0;
        all_done = 1'b0;
        while (!all_done) begin
            if (cycles == TIMEOUT_CYCLES) begin
                report_failure($sformatf("%s: timed out waiting for tx_done", name));
            end else begin
                advance(name, 1'b0);
                cycles++;
                all_done = 1'b1;
                for (s = 0; s < 3; s++) begin
                    if (pending[s] && (done_count[s] == 0)) begin
                        all_done = 1'b0;
                    end
                end
            end
        end
    endtask

    initial begin
        int         i;
        int         k;
        entry_t     e;
        logic [2:0] pending;
        string      name;
        seed     = 32'h633b_f543;
        rst_n    = 1'b0;
        req_src1 = '0;
        req_src2 = '0;
        req_src3 = '0;
        for (k = 0; k < 3; k++) begin
            drv_req[k] = '0;
        end
        exp_sel   = SRC1;
        exp_cnt   = 0;
        exp_src   = SRC1;
        exp_op    = OP_IDLE;
        exp_idx   = '0;
        exp_wdata = '0;
        build_table();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        for (k = 0; k < IDLE_CYCLES; k++) begin
            advance("after reset", 1'b1);
        end
        i = 0;
        while (i < tbl.size()) begin
            name    = $sformatf("entry %0d", i);
            pending = '0;
            // Joined entries are raised in the same cycle
            do begin
                e = tbl[i];
                drv_req[int'(e.src)].op             = e.op;
                drv_req[int'(e.src)].raw_address    = e.raw;
                drv_req[int'(e.src)].address_offset = e.offset;
                drv_req[int'(e.src)].wdata          = e.wdata;
                pending[int'(e.src)] = 1'b1;
                i++;
            end while (e.joined && (i < tbl.size()));
            run_batch(name, pending);
        end
        $display("Test OK");
        $finish;
    end

endmodule

// File: src.f
rtl/mem_sys_pkg.sv
rtl/mem_access_timer.sv
rtl/mem_line_store.sv
rtl/mem_ctrl.sv
rtl/mem_arbiter.sv
rtl/mem_subsystem_top.sv
tb/tb_mem_subsystem.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_subsystem
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard rtl/*.sv tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The simulator exits nonzero on $fatal, so make fails with it
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
